// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tetris_tb
FILELIST := all.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only if the pass message shows up in the output
run: compile
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+src
src/tetris_pkg.sv
src/button_debounce.sv
src/game_engine.sv
src/beat_fifo.sv
src/frame_renderer.sv
src/tetris_top.sv
dv/tetris_tb.sv

// File: dv/tetris_tb.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module tetris_tb;

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int FRAME   = H_TOTAL * V_TOTAL;
  // Lines from the vsync fall to line 0 of the next frame
  localparam int VS_LEAD = V_TOTAL - `V_ACTIVE - `V_FRONT;
  localparam int BX1     = `GRID_X0 + `GRID_W * `CELL_PX;
  localparam int BY1     = `GRID_Y0 + `GRID_H * `CELL_PX;
  // Scan ends one line below the bottom border
  localparam int SCAN_END = (VS_LEAD + BY1 + 1) * H_TOTAL;
  localparam int MID_X    = (`GRID_X0 + BX1) / 2;
  localparam int MID_Y    = (`GRID_Y0 + BY1) / 2;
  localparam int HOLD     = 40;

  // Move codes for stimulus and model
  localparam int MV_NONE  = 0;
  localparam int MV_LEFT  = 1;
  localparam int MV_RIGHT = 2;

  logic       clk_i;
  logic       rst_n_i;
  logic       btn_left_i;
  logic       btn_right_i;
  logic       btn_drop_i;
  logic       btn_start_i;
  logic [2:0] rgb_o;
  logic       hsync_o;
  logic       vsync_o;
  logic [9:0] score_o;
  logic       game_over_o;

  // Reference board, locked cells only
  logic [2:0] m_board [`GRID_H][`GRID_W];
  int         m_row;
  int         m_col;
  logic [2:0] m_color;
  logic [9:0] m_score;
  logic       m_over;
  logic       m_live;

  // Presses waiting for the next game step
  int         p_move;
  logic       p_drop;
  logic       p_start;

  int          checks;
  int          errors;
  logic [31:0] seed;

  // Raster watch
  int   h_cnt;
  int   h_low;
  int   v_cnt;
  int   v_low;
  logic hs_prev;
  logic vs_prev;
  logic h_seen;
  logic v_seen;

  tetris_top uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .btn_left_i  (btn_left_i),
    .btn_right_i (btn_right_i),
    .btn_drop_i  (btn_drop_i),
    .btn_start_i (btn_start_i),
    .rgb_o       (rgb_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .score_o     (score_o),
    .game_over_o (game_over_o)
  );

  always #5 clk_i = ~clk_i;

  // ====================
  // Checkers
  // ====================

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERROR: %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Sync widths and periods, seen at the falling clock
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      h_cnt   = 0;
      h_low   = 0;
      v_cnt   = 0;
      v_low   = 0;
      hs_prev = 1'b1;
      vs_prev = 1'b1;
      h_seen  = 1'b0;
      v_seen  = 1'b0;
    end else begin
      if (hs_prev && !hsync_o) begin
        if (h_seen) check_value("hsync_o period", H_TOTAL, h_cnt);
        h_seen = 1'b1;
        h_cnt  = 0;
        h_low  = 0;
      end
      if (!hs_prev && hsync_o && h_seen) check_value("hsync_o low width", `H_SYNC, h_low);
      if (vs_prev && !vsync_o) begin
        if (v_seen) check_value("vsync_o period", FRAME, v_cnt);
        v_seen = 1'b1;
        v_cnt  = 0;
        v_low  = 0;
      end
      if (!vs_prev && vsync_o && v_seen) begin
        check_value("vsync_o low width", `V_SYNC * H_TOTAL, v_low);
      end
      h_cnt++;
      v_cnt++;
      if (!hsync_o) h_low++;
      if (!vsync_o) v_low++;
      hs_prev = hsync_o;
      vs_prev = vsync_o;
    end
  end

  // Game state moves only in vertical blanking, where the picture is black
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (score_o != $past(score_o) || game_over_o != $past(game_over_o)) |-> rgb_o == 3'd0)
  else begin
    errors++;
    $display("score_o or game_over_o changed while a picture was being drawn");
  end

  // ====================
  // Reference model
  // ====================

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic can_fall();
    return (m_row < `GRID_H - 1) && (m_board[m_row+1][m_col] == 3'd0);
  endfunction

  // Cell as the screen should show it
  function automatic logic [2:0] exp_cell(input int r, input int c);
    logic [2:0] v;
    v = m_board[r][c];
    if (m_live && r == m_row && c == m_col) v = m_color;
    if (m_over && v == 3'd0) v = 3'd4;
    return v;
  endfunction

  task automatic clear_board();
    for (int r = 0; r < `GRID_H; r++) begin
      for (int c = 0; c < `GRID_W; c++) begin
        m_board[r][c] = 3'd0;
      end
    end
  endtask

  // One game step, rules in order
  task automatic model_step();
    int   r;
    logic full;
    if (!m_live) begin
      if (p_start) begin
        clear_board();
        m_score = 10'd0;
        m_over  = 1'b0;
        m_live  = 1'b1;
        m_row   = 0;
        m_col   = `SPAWN_COL;
        m_color = 3'd1;
      end
    end else begin
      if (p_move == MV_LEFT && m_col > 0 && m_board[m_row][m_col-1] == 3'd0) begin
        m_col--;
      end else if (p_move == MV_RIGHT && m_col < `GRID_W - 1 &&
                   m_board[m_row][m_col+1] == 3'd0) begin
        m_col++;
      end
      if (can_fall()) begin
        m_row++;
        while (p_drop && can_fall()) m_row++;
      end else begin
        m_board[m_row][m_col] = m_color;
        // Remove full rows from the bottom up
        r = `GRID_H - 1;
        while (r >= 0) begin
          full = 1'b1;
          for (int c = 0; c < `GRID_W; c++) begin
            if (m_board[r][c] == 3'd0) full = 1'b0;
          end
          if (full) begin
            for (int rr = r; rr > 0; rr--) begin
              for (int c = 0; c < `GRID_W; c++) begin
                m_board[rr][c] = m_board[rr-1][c];
              end
            end
            for (int c = 0; c < `GRID_W; c++) begin
              m_board[0][c] = 3'd0;
            end
            m_score++;
          end else begin
            r--;
          end
        end
        m_row   = 0;
        m_col   = `SPAWN_COL;
        m_color = (m_color == 3'd6) ? 3'd1 : m_color + 3'd1;
        if (m_board[0][`SPAWN_COL] != 3'd0) begin
          m_over = 1'b1;
          m_live = 1'b0;
        end
      end
    end
    p_move  = MV_NONE;
    p_drop  = 1'b0;
    p_start = 1'b0;
  endtask

  // ====================
  // Stimulus and sampling
  // ====================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic press(input int mv, input logic drop, input logic start);
    @(posedge clk_i);
    #1;
    btn_left_i  = (mv == MV_LEFT);
    btn_right_i = (mv == MV_RIGHT);
    btn_drop_i  = drop;
    btn_start_i = start;
    repeat (HOLD) @(posedge clk_i);
    #1;
    btn_left_i  = 1'b0;
    btn_right_i = 1'b0;
    btn_drop_i  = 1'b0;
    btn_start_i = 1'b0;
    // Release settles, no pulse on it
    repeat (`DEBOUNCE_CYCLES + 4) @(posedge clk_i);
    p_move  = mv;
    p_drop  = drop;
    p_start = start;
  endtask

  task automatic wait_vsync_fall();
    int   n;
    logic prev;
    logic seen;
    n    = 0;
    prev = 1'b0;
    seen = 1'b0;
    while (!seen && n < 2 * FRAME) begin
      @(negedge clk_i);
      seen = prev && !vsync_o;
      prev = vsync_o;
      n++;
    end
    if (!seen) abort_run("vsync_o did not fall within two frame times");
  endtask

  task automatic check_pixel(input int r, input int c);
    logic [2:0] exp;
    exp = exp_cell(r, c);
    checks++;
    assert (rgb_o === exp) else begin
      errors++;
      $display("ERROR: rgb_o at row %0d col %0d expected %h actual %h", r, c, exp, rgb_o);
    end
  endtask

  // rgb_o at negedge k after the vsync fall shows raster offset k from line 122
  task automatic check_frame();
    int x;
    int y;
    check_value("score_o", m_score, score_o);
    check_value("game_over_o", m_over, game_over_o);
    for (int k = 1; k <= SCAN_END; k++) begin
      @(negedge clk_i);
      x = k % H_TOTAL;
      y = k / H_TOTAL - VS_LEAD;
      if (y >= `GRID_Y0 && y < BY1 && x >= `GRID_X0 && x < BX1 &&
          (y - `GRID_Y0) % `CELL_PX == `CELL_PX / 2 &&
          (x - `GRID_X0) % `CELL_PX == `CELL_PX / 2) begin
        check_pixel((y - `GRID_Y0) / `CELL_PX, (x - `GRID_X0) / `CELL_PX);
      end else if (((x == `GRID_X0 - 1 || x == BX1) && y == MID_Y) ||
                   ((y == `GRID_Y0 - 1 || y == BY1) && x == MID_X)) begin
        check_value("rgb_o on the border", 7, rgb_o);
      end
    end
  endtask

  // Presses in mid frame, then the step and a full picture check
  task automatic run_frame(input int mv, input logic drop, input logic start);
    if (mv != MV_NONE || drop || start) press(mv, drop, start);
    wait_vsync_fall();
    model_step();
    check_frame();
  endtask

  // Walk the block to a column, drop it, let it lock
  task automatic place(input int col);
    int guard;
    guard = 0;
    while (m_live && m_col != col && guard < `GRID_W) begin
      run_frame((m_col > col) ? MV_LEFT : MV_RIGHT, 1'b0, 1'b0);
      guard++;
    end
    run_frame(MV_NONE, 1'b1, 1'b0);
    run_frame(MV_NONE, 1'b0, 1'b0);
  endtask

  // Stack the spawn column until the game ends
  task automatic stack_spawn();
    int n;
    n = 0;
    while (!m_over && n < 2 * `GRID_H) begin
      place(`SPAWN_COL);
      n++;
    end
    check_value("game_over_o", 1, game_over_o);
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    int n;
    int fill_cols [8] = '{0, 1, 2, 3, 6, 7, 8, 9};
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    btn_left_i  = 1'b0;
    btn_right_i = 1'b0;
    btn_drop_i  = 1'b0;
    btn_start_i = 1'b0;
    checks      = 0;
    errors      = 0;
    seed        = 32'h5340_d9c5;
    clear_board();
    m_row   = 0;
    m_col   = `SPAWN_COL;
    m_color = 3'd0;
    m_score = 10'd0;
    m_over  = 1'b0;
    m_live  = 1'b0;
    p_move  = MV_NONE;
    p_drop  = 1'b0;
    p_start = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // Idle board after reset
    run_frame(MV_NONE, 1'b0, 1'b0);
    run_frame(MV_NONE, 1'b0, 1'b0);

    // Untouched block falls to the floor, locks, next color spawns
    run_frame(MV_NONE, 1'b0, 1'b1);
    repeat (`GRID_H) run_frame(MV_NONE, 1'b0, 1'b0);

    // Both walls, one push past each
    repeat (5) run_frame(MV_LEFT, 1'b0, 1'b0);
    repeat (10) run_frame(MV_RIGHT, 1'b0, 1'b0);
    run_frame(MV_NONE, 1'b1, 1'b0);

    // Random moves and drops
    for (n = 0; n < 40; n++) begin
      seed = lcg_next(seed);
      run_frame(int'(seed[17:16]) % 3, seed[22:21] == 2'd0, 1'b0);
    end

    stack_spawn();
    // Frozen, moves and drops do nothing
    run_frame(MV_LEFT, 1'b1, 1'b0);
    run_frame(MV_RIGHT, 1'b0, 1'b0);
    run_frame(MV_NONE, 1'b0, 1'b1);
    check_value("game_over_o", 0, game_over_o);

    // Two in the spawn column, the upper one shifts down later
    place(`SPAWN_COL);
    place(`SPAWN_COL);
    // Rest beside a locked cell, then push into it
    run_frame(MV_RIGHT, 1'b0, 1'b0);
    run_frame(MV_NONE, 1'b1, 1'b0);
    run_frame(MV_LEFT, 1'b0, 1'b0);
    foreach (fill_cols[i]) begin
      place(fill_cols[i]);
    end
    check_value("score_o", 1, score_o);

    // Game over with a nonzero score, start brings it back to 0
    stack_spawn();
    run_frame(MV_NONE, 1'b0, 1'b1);
    check_value("score_o", 0, score_o);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: src/beat_fifo.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module beat_fifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    in_valid_i,
  input  tetris_pkg::frame_beat_t in_beat_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output tetris_pkg::frame_beat_t out_beat_o,
  input  logic                    out_ready_i
);

  localparam int AW = $clog2(DEPTH);

  tetris_pkg::frame_beat_t mem_q [DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr_q;
  logic [AW:0] rd_ptr_q;
  logic        empty;
  logic        full;
  logic        push;
  logic        pop;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                 (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

  assign in_ready_o  = !full;
  assign out_valid_o = !empty;
  // Head word shows without a pop
  assign out_beat_o  = mem_q[rd_ptr_q[AW-1:0]];

  // Pop strobes on empty do nothing
  assign push = in_valid_i && !full;
  assign pop  = out_ready_i && !empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[AW-1:0]] <= in_beat_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

endmodule

// File: src/button_debounce.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module button_debounce (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic btn_i,
  output logic press_o
);

  localparam int CW = $clog2(`DEBOUNCE_CYCLES);
  localparam logic [CW-1:0] CNT_MAX = CW'(`DEBOUNCE_CYCLES - 1);

  // Two-flop synchronizer, bit 1 is safe to use
  logic [1:0]    sync_q;
  logic [CW-1:0] cnt_q;
  logic          stable_q;
  logic          settle;

  // Input held away from stable level long enough
  assign settle = (sync_q[1] != stable_q) && (cnt_q == CNT_MAX);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q   <= 2'b00;
      cnt_q    <= '0;
      stable_q <= 1'b0;
      press_o  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], btn_i};
      // Any bounce back restarts the count
      if (sync_q[1] == stable_q) begin
        cnt_q <= '0;
      end else if (settle) begin
        cnt_q    <= '0;
        stable_q <= sync_q[1];
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Pulse on press only, release is silent
      press_o <= settle && sync_q[1];
    end
  end

endmodule

// File: src/frame_renderer.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module frame_renderer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    beat_valid_i,
  input  tetris_pkg::frame_beat_t beat_i,
  output logic                    beat_ready_o,
  output logic                    frame_tick_o,
  output tetris_pkg::color_t      rgb_o,
  output logic                    hsync_o,
  output logic                    vsync_o
);

  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int XW = $clog2(H_TOTAL);
  localparam int YW = $clog2(V_TOTAL);

  // Board edges, upper bounds exclusive
  localparam int BX0 = `GRID_X0;
  localparam int BX1 = `GRID_X0 + `GRID_W * `CELL_PX;
  localparam int BY0 = `GRID_Y0;
  localparam int BY1 = `GRID_Y0 + `GRID_H * `CELL_PX;

  // Sync windows
  localparam int HS0 = `H_ACTIVE + `H_FRONT;
  localparam int HS1 = HS0 + `H_SYNC;
  localparam int VS0 = `V_ACTIVE + `V_FRONT;
  localparam int VS1 = VS0 + `V_SYNC;

  logic [XW-1:0] x_q, x_d;
  logic [YW-1:0] y_q, y_d;

  // Last header and the row in view
  tetris_pkg::frame_hdr_t hdr_q;
  tetris_pkg::cell_row_t  row_q;
  logic                   pop_row_q;

  logic               at_hdr;
  logic               at_row;
  tetris_pkg::color_t pix_d;

  // ====================
  // Raster
  // ====================

  always_comb begin
    x_d = x_q + 1'b1;
    y_d = y_q;
    if (x_q == XW'(H_TOTAL - 1)) begin
      x_d = '0;
      y_d = (y_q == YW'(V_TOTAL - 1)) ? '0 : y_q + 1'b1;
    end
  end

  // Read points, looked up one clock early
  always_comb begin
    int ny;
    ny     = int'(y_d);
    at_hdr = (x_d == '0) && (y_d == '0);
    at_row = (x_d == '0) && (ny >= BY0) && (ny < BY1) &&
             ((ny - BY0) % `CELL_PX == 0);
  end

  // ====================
  // Pixel
  // ====================

  always_comb begin
    int   px;
    int   py;
    int   cidx;
    logic in_board;
    logic in_ring;
    px       = int'(x_q);
    py       = int'(y_q);
    in_board = (px >= BX0) && (px < BX1) && (py >= BY0) && (py < BY1);
    // One pixel frame around the board
    in_ring  = !in_board && (px >= BX0 - 1) && (px <= BX1) &&
               (py >= BY0 - 1) && (py <= BY1);
    cidx     = in_board ? (px - BX0) / `CELL_PX : 0;
    pix_d    = tetris_pkg::COLOR_BG;
    if (in_ring) begin
      pix_d = tetris_pkg::COLOR_WHITE;
    end else if (in_board) begin
      pix_d = row_q[cidx];
      // Red floor once the game is over
      if (pix_d == tetris_pkg::COLOR_BG && hdr_q.game_over) begin
        pix_d = tetris_pkg::COLOR_RED;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      x_q          <= '0;
      y_q          <= '0;
      beat_ready_o <= 1'b0;
      pop_row_q    <= 1'b0;
      frame_tick_o <= 1'b0;
      hsync_o      <= 1'b1;
      vsync_o      <= 1'b1;
      rgb_o        <= tetris_pkg::COLOR_BG;
      hdr_q        <= '0;
      row_q        <= '0;
    end else begin
      x_q          <= x_d;
      y_q          <= y_d;
      beat_ready_o <= at_hdr || at_row;
      pop_row_q    <= at_row;
      // First front porch line
      frame_tick_o <= (x_d == '0) && (int'(y_d) == `V_ACTIVE);
      hsync_o      <= !((int'(x_q) >= HS0) && (int'(x_q) < HS1));
      vsync_o      <= !((int'(y_q) >= VS0) && (int'(y_q) < VS1));
      rgb_o        <= pix_d;
      if (beat_ready_o) begin
        if (beat_valid_i) begin
          if (beat_i.is_hdr) begin
            hdr_q <= beat_i.payload.hdr;
          end else begin
            row_q <= beat_i.payload.row;
          end
        end else if (pop_row_q) begin
          // Missing row shows empty
          row_q <= '0;
        end
      end
    end
  end

endmodule

// File: src/game_engine.sv
`timescale 1ns/1ps
`include "tetris_settings.svh"

module game_engine (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    frame_tick_i,
  input  logic                    left_i,
  input  logic                    right_i,
  input  logic                    drop_i,
  input  logic                    start_i,
  input  logic                    beat_ready_i,
  output logic                    beat_valid_o,
  output tetris_pkg::frame_beat_t beat_o,
  output logic [9:0]              score_o,
  output logic                    game_over_o
);

  localparam logic [4:0] LAST_ROW  = 5'(`GRID_H - 1);
  localparam logic [3:0] LAST_COL  = 4'(`GRID_W - 1);
  localparam logic [3:0] SPAWN_COL = 4'(`SPAWN_COL);
  localparam logic [4:0] LAST_BEAT = 5'(`GRID_H);

  // Pending move codes
  localparam logic [1:0] MV_NONE  = 2'd0;
  localparam logic [1:0] MV_LEFT  = 2'd1;
  localparam logic [1:0] MV_RIGHT = 2'd2;

  // Locked cells only, falling block kept apart
  tetris_pkg::cell_row_t board_q [`GRID_H];
  tetris_pkg::cell_row_t board_d [`GRID_H];

  logic [4:0]         blk_row_q, blk_row_d;
  logic [3:0]         blk_col_q, blk_col_d;
  tetris_pkg::color_t blk_color_q, blk_color_d;
  logic [9:0]         score_q, score_d;
  logic               over_q, over_d;
  logic               live_q, live_d;

  // Inputs latched between ticks
  logic [1:0] move_q;
  logic       drop_q;
  logic       start_q;

  // Beat walker, 0 is the header
  logic [4:0] beat_idx_q;

  // ====================
  // Game step
  // ====================

  always_comb begin
    logic moved;
    logic full;
    moved       = 1'b0;
    full        = 1'b1;
    board_d     = board_q;
    blk_row_d   = blk_row_q;
    blk_col_d   = blk_col_q;
    blk_color_d = blk_color_q;
    score_d     = score_q;
    over_d      = over_q;
    live_d      = live_q;
    if (!live_q) begin
      // Idle or game over, only start acts
      if (start_q) begin
        for (int r = 0; r < `GRID_H; r++) begin
          board_d[r] = '0;
        end
        score_d     = 10'd0;
        over_d      = 1'b0;
        live_d      = 1'b1;
        blk_row_d   = 5'd0;
        blk_col_d   = SPAWN_COL;
        blk_color_d = 3'd1;
      end
    end else begin
      // Side move, walls and locked cells block it
      if (move_q == MV_LEFT && blk_col_d != 4'd0 &&
          board_d[blk_row_d][blk_col_d - 4'd1] == tetris_pkg::COLOR_BG) begin
        blk_col_d = blk_col_d - 4'd1;
      end else if (move_q == MV_RIGHT && blk_col_d != LAST_COL &&
                   board_d[blk_row_d][blk_col_d + 4'd1] == tetris_pkg::COLOR_BG) begin
        blk_col_d = blk_col_d + 4'd1;
      end
      // One row of gravity, or all the way down on fast drop
      for (int i = 0; i < `GRID_H; i++) begin
        if ((i == 0 || drop_q) && blk_row_d != LAST_ROW &&
            board_d[blk_row_d + 5'd1][blk_col_d] == tetris_pkg::COLOR_BG) begin
          blk_row_d = blk_row_d + 5'd1;
          moved     = 1'b1;
        end
      end
      if (!moved) begin
        // Resting, lock it
        board_d[blk_row_d][blk_col_d] = blk_color_d;
        // Only the lock row can have filled up
        for (int c = 0; c < `GRID_W; c++) begin
          if (board_d[blk_row_d][c] == tetris_pkg::COLOR_BG) begin
            full = 1'b0;
          end
        end
        if (full) begin
          for (int r = `GRID_H - 1; r > 0; r--) begin
            if (r <= blk_row_d) begin
              board_d[r] = board_d[r-1];
            end
          end
          board_d[0] = '0;
          score_d    = score_d + 10'd1;
        end
        // Next block, color cycles 1 to 6
        blk_row_d   = 5'd0;
        blk_col_d   = SPAWN_COL;
        blk_color_d = (blk_color_d == 3'd6) ? 3'd1 : blk_color_d + 3'd1;
        // Blocked spawn ends the game, board stays as is
        if (board_d[0][SPAWN_COL] != tetris_pkg::COLOR_BG) begin
          over_d = 1'b1;
          live_d = 1'b0;
        end
      end
    end
  end

  // ====================
  // State and beat walk
  // ====================

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      board_q      <= '{default: '0};
      blk_row_q    <= 5'd0;
      blk_col_q    <= SPAWN_COL;
      blk_color_q  <= tetris_pkg::COLOR_BG;
      score_q      <= 10'd0;
      over_q       <= 1'b0;
      live_q       <= 1'b0;
      move_q       <= MV_NONE;
      drop_q       <= 1'b0;
      start_q      <= 1'b0;
      beat_idx_q   <= 5'd0;
      beat_valid_o <= 1'b0;
    end else begin
      // Latest move wins, a press on the tick waits for the next one
      if (left_i) begin
        move_q <= MV_LEFT;
      end else if (right_i) begin
        move_q <= MV_RIGHT;
      end else if (frame_tick_i) begin
        move_q <= MV_NONE;
      end
      if (drop_i) begin
        drop_q <= 1'b1;
      end else if (frame_tick_i) begin
        drop_q <= 1'b0;
      end
      if (start_i) begin
        start_q <= 1'b1;
      end else if (frame_tick_i) begin
        start_q <= 1'b0;
      end

      if (frame_tick_i) begin
        board_q      <= board_d;
        blk_row_q    <= blk_row_d;
        blk_col_q    <= blk_col_d;
        blk_color_q  <= blk_color_d;
        score_q      <= score_d;
        over_q       <= over_d;
        live_q       <= live_d;
        // Restart the stream with the header
        beat_idx_q   <= 5'd0;
        beat_valid_o <= 1'b1;
      end else if (beat_valid_o && beat_ready_i) begin
        if (beat_idx_q == LAST_BEAT) begin
          beat_valid_o <= 1'b0;
        end else begin
          beat_idx_q <= beat_idx_q + 5'd1;
        end
      end
    end
  end

  // Beat built from settled state, stable while stalled
  always_comb begin
    logic [4:0] row_idx;
    row_idx = beat_idx_q - 5'd1;
    beat_o  = '0;
    if (beat_idx_q == 5'd0) begin
      beat_o.is_hdr                  = 1'b1;
      beat_o.payload.hdr.score       = score_q;
      beat_o.payload.hdr.game_over   = over_q;
      beat_o.payload.hdr.piece_color = blk_color_q;
    end else begin
      beat_o.payload.row = board_q[row_idx];
      // Falling block merged into its row
      if (live_q && blk_row_q == row_idx) begin
        beat_o.payload.row[blk_col_q] = blk_color_q;
      end
    end
  end

  assign score_o     = score_q;
  assign game_over_o = over_q;

endmodule

// File: src/tetris_pkg.sv
`include "tetris_settings.svh"

package tetris_pkg;

  // 3-bit cell color, 0 is empty
  typedef logic [2:0] color_t;

  localparam color_t COLOR_BG    = 3'd0;
  localparam color_t COLOR_RED   = 3'd4;
  localparam color_t COLOR_WHITE = 3'd7;

  // One board row, column 0 in the low bits
  typedef color_t [`GRID_W-1:0] cell_row_t;

  // Per-frame status word
  typedef struct packed {
    logic [9:0]  score;
    logic        game_over;
    color_t      piece_color;
    logic [15:0] pad;
  } frame_hdr_t;

  // Beat payload, decoded by is_hdr
  typedef union packed {
    cell_row_t  row;
    frame_hdr_t hdr;
  } beat_payload_u;

  // Header beat or row beat
  typedef struct packed {
    logic          is_hdr;
    beat_payload_u payload;
  } frame_beat_t;

endpackage

// File: src/tetris_settings.svh
`ifndef TETRIS_SETTINGS_SVH
`define TETRIS_SETTINGS_SVH

// Board size in cells
`define GRID_W 10
`define GRID_H 20

// Cell side and board origin in pixels
`define CELL_PX 4
`define GRID_X0 8
`define GRID_Y0 8

// Horizontal raster, 176 clocks per line
`define H_ACTIVE 160
`define H_FRONT 4
`define H_SYNC 8
`define H_BACK 4

// Vertical raster, 128 lines per frame
`define V_ACTIVE 120
`define V_FRONT 2
`define V_SYNC 2
`define V_BACK 4

// Beat buffer and button filter
`define FIFO_DEPTH 4
`define DEBOUNCE_CYCLES 16

// New blocks drop in here
`define SPAWN_COL 4

`endif

// File: src/tetris_top.sv
`timescale 1ns/1ps

module tetris_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               btn_left_i,
  input  logic               btn_right_i,
  input  logic               btn_drop_i,
  input  logic               btn_start_i,
  output tetris_pkg::color_t rgb_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output logic [9:0]         score_o,
  output logic               game_over_o
);

  // Press pulses
  logic left_p;
  logic right_p;
  logic drop_p;
  logic start_p;

  logic frame_tick;

  // Engine side of the buffer
  logic                    eng_valid;
  logic                    eng_ready;
  tetris_pkg::frame_beat_t eng_beat;

  // Renderer side of the buffer
  logic                    fifo_valid;
  logic                    rend_ready;
  tetris_pkg::frame_beat_t fifo_beat;

  // ====================
  // Buttons
  // ====================

  button_debounce u_db_left (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .btn_i   (btn_left_i),
    .press_o (left_p)
  );

  button_debounce u_db_right (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .btn_i   (btn_right_i),
    .press_o (right_p)
  );

  button_debounce u_db_drop (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .btn_i   (btn_drop_i),
    .press_o (drop_p)
  );

  button_debounce u_db_start (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .btn_i   (btn_start_i),
    .press_o (start_p)
  );

  // ====================
  // Game and display
  // ====================

  game_engine u_engine (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .frame_tick_i (frame_tick),
    .left_i       (left_p),
    .right_i      (right_p),
    .drop_i       (drop_p),
    .start_i      (start_p),
    .beat_ready_i (eng_ready),
    .beat_valid_o (eng_valid),
    .beat_o       (eng_beat),
    .score_o      (score_o),
    .game_over_o  (game_over_o)
  );

  beat_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (eng_valid),
    .in_beat_i   (eng_beat),
    .in_ready_o  (eng_ready),
    .out_valid_o (fifo_valid),
    .out_beat_o  (fifo_beat),
    .out_ready_i (rend_ready)
  );

  frame_renderer u_render (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .beat_valid_i (fifo_valid),
    .beat_i       (fifo_beat),
    .beat_ready_o (rend_ready),
    .frame_tick_o (frame_tick),
    .rgb_o        (rgb_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o)
  );

endmodule
